//--- dv/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

  localparam int unsigned CLK_PERIOD        = 40;
  localparam int unsigned RESET_CYCLES      = 16;
  localparam int unsigned MEM_WORDS         = 256;
  localparam int unsigned NUM_INSTS         = 400;
  localparam int unsigned MAX_BUS_DELAY     = 4;
  localparam int unsigned MAX_REDIRECT_WAIT = 3;
  localparam int unsigned WORST_REFILL      = 2 * MAX_BUS_DELAY + 3;  // request, two beats, write, hit
  // factor two leaves room for the cycles with next_ready_i low
  localparam int unsigned WATCHDOG_CYCLES   =
    RESET_CYCLES + NUM_INSTS * (WORST_REFILL + MAX_REDIRECT_WAIT + 2) * 2;
  localparam logic [31:0] LCG_SEED          = 32'h597b_6867;

  localparam logic [6:0]  OPC_ALU      = 7'b011_0011;
  localparam logic [6:0]  OPC_BRANCH   = 7'b110_0011;
  localparam logic [6:0]  OPC_LOAD     = 7'b000_0011;
  localparam logic [31:0] FENCE_I_WORD = 32'h0000_100f;

  typedef struct packed {
    logic              busy;
    logic [1:0]        wait_cnt;
    icache_pkg::addr_t addr;
  } bus_req_t;

  typedef struct packed {
    logic        valid;
    logic [28:0] line;  // address bits 31:3
  } line_track_t;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  icache_pkg::addr_t bus_araddr;
  logic              bus_arvalid;
  rv_isa_pkg::inst_t bus_rdata = '0;
  logic              bus_rvalid = 1'b0;
  logic              next_ready = 1'b0;
  logic              redirect = 1'b0;
  icache_pkg::addr_t npc = '0;
  rv_isa_pkg::inst_t inst;
  icache_pkg::addr_t pc;
  logic              valid;

  rv_isa_pkg::inst_t mem [MEM_WORDS];
  logic [31:0]       rng = LCG_SEED;
  logic              mem_filled = 1'b0;
  bus_req_t          req = '0;
  logic [1:0]        redirect_wait = 2'd0;
  icache_pkg::addr_t stalled_pc = '0;

  line_track_t       cached [icache_pkg::NUM_SETS];
  logic              rst_d = 1'b0;
  logic              prev_valid = 1'b0;
  logic              prev_ready = 1'b0;
  icache_pkg::addr_t prev_pc = '0;
  rv_isa_pkg::inst_t prev_inst = '0;
  logic              prev_arvalid = 1'b0;
  logic              prev_rvalid = 1'b0;
  icache_pkg::addr_t prev_araddr = '0;
  icache_pkg::addr_t exp_pc = '0;
  logic              exp_known = 1'b0;
  logic              wait_redirect = 1'b0;
  logic              beat_odd = 1'b0;
  logic [28:0]       refill_line = '0;
  int unsigned       errors = 0;
  int unsigned       accepted = 0;
  int unsigned       refills = 0;
  int unsigned       fences = 0;

  fetch_top uut (
    .clk           (clk),
    .rst           (rst),
    .bus_araddr_o  (bus_araddr),
    .bus_arvalid_o (bus_arvalid),
    .bus_rdata_i   (bus_rdata),
    .bus_rvalid_i  (bus_rvalid),
    .next_ready_i  (next_ready),
    .redirect_i    (redirect),
    .npc_i         (npc),
    .inst_o        (inst),
    .pc_o          (pc),
    .valid_o       (valid)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // jal, jalr, branch, system and load all end sequential fetch
  function automatic logic waits_for_redirect(input rv_isa_pkg::inst_t word);
    logic [6:0] op;
    op = word[6:0];
    return (op == 7'b110_1111) || (op == 7'b110_0111) || (op == OPC_BRANCH) ||
           (op == 7'b111_0011) || (op == OPC_LOAD);
  endfunction

  function automatic rv_isa_pkg::inst_t mem_word(input icache_pkg::addr_t addr);
    return mem[addr[9:2]];
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      rng = lcg_next(rng);
      mem[8'(i)] = rng;
      case (rng[31:29])  // upper bits are the better LCG bits
        3'd6: mem[8'(i)][6:0] = OPC_BRANCH;
        3'd7: mem[8'(i)][6:0] = OPC_LOAD;
        default: mem[8'(i)][6:0] = OPC_ALU;
      endcase
      if (i % 16 == 9) begin
        mem[8'(i)] = FENCE_I_WORD;
      end
    end
    mem[8'(MEM_WORDS - 1)][6:0] = OPC_BRANCH;  // sequential fetch never runs past the last word
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("Fail %s: expected %h, actual %h at %0t", test, expected, actual, $time);
  endtask

  task automatic log_fault(input string what);
    errors++;
    $display("error: %s at %0t", what, $time);
  endtask

  initial begin
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    while (accepted < NUM_INSTS) @(negedge clk);
    @(negedge clk);
    $display("errors: %0d  accepted: %0d  refills: %0d  fence.i: %0d",
             errors, accepted, refills, fences);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("error: watchdog expired after %0d cycles with %0d instructions accepted",
             WATCHDOG_CYCLES, accepted);
    $display("Verification failed");
    $finish;
  end

  // bus memory model and decode side both drive on the rising edge
  always @(posedge clk) begin
    logic [31:0] r;
    rng = lcg_next(rng);
    r = rng;
    if (rst) begin
      if (!mem_filled) begin
        fill_memory();
        mem_filled = 1'b1;
      end
      req           <= '0;
      bus_rvalid    <= 1'b0;
      next_ready    <= 1'b0;
      redirect      <= 1'b0;
      redirect_wait <= 2'd0;
    end else begin
      if (bus_rvalid) begin
        bus_rvalid <= 1'b0;  // one pulse answers one request
        req.busy   <= 1'b0;
      end else if (bus_arvalid && !req.busy) begin
        req.busy     <= 1'b1;
        req.wait_cnt <= r[29:28];
        req.addr     <= bus_araddr;
      end else if (req.busy) begin
        if (req.wait_cnt == 2'd0) begin
          bus_rvalid <= 1'b1;
          bus_rdata  <= mem_word(req.addr);
        end else begin
          req.wait_cnt <= req.wait_cnt - 2'd1;
        end
      end
      next_ready <= (r[31:30] != 2'b00);  // ready three cycles in four
      redirect   <= 1'b0;
      if (valid && next_ready && waits_for_redirect(inst)) begin
        redirect_wait <= (r[27:26] == 2'd3) ? 2'd1 : r[27:26] + 2'd1;
        stalled_pc    <= pc;
      end else if (redirect_wait == 2'd1) begin
        redirect      <= 1'b1;
        redirect_wait <= 2'd0;
        if (r[25]) begin
          npc <= {stalled_pc[31:3], r[24], 2'b00};  // back into a line already fetched
        end else begin
          npc <= icache_pkg::PC_INIT + {22'd0, r[23:16], 2'b00};
        end
      end else if (redirect_wait != 2'd0) begin
        redirect_wait <= redirect_wait - 2'd1;
      end
    end
  end

  // checks sample the values that settled before the edge
  always @(posedge clk) begin
    logic [1:0] idx;
    if (rst_d) begin
      assert (!valid) else log_fault("valid_o high during or right after reset");
      assert (!bus_arvalid) else log_fault("bus_arvalid_o high during or right after reset");
      assert (pc == icache_pkg::PC_INIT)
        else report_mismatch("reset_pc", icache_pkg::PC_INIT, pc);
    end
    if (rst) begin
      for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
        cached[2'(s)] = '0;
      end
      wait_redirect = 1'b0;
      exp_known     = 1'b0;
      beat_odd      = 1'b0;
    end else begin
      if (valid) begin
        idx = pc[4:3];
        assert (inst == mem_word(pc)) else report_mismatch("fetch_data", mem_word(pc), inst);
        assert (cached[idx].valid && cached[idx].line == pc[31:3])
          else log_fault("valid_o on a line not refilled since reset or the last fence.i");
        if (exp_known) begin
          assert (pc == exp_pc) else report_mismatch("next_pc", exp_pc, pc);
          exp_known = 1'b0;
        end
      end
      if (prev_valid && !prev_ready) begin
        assert (valid) else log_fault("valid_o dropped while next_ready_i was low");
        assert (pc == prev_pc) else report_mismatch("hold_pc", prev_pc, pc);
        assert (inst == prev_inst) else report_mismatch("hold_inst", prev_inst, inst);
      end
      if (wait_redirect) begin
        assert (!valid) else log_fault("valid_o high while waiting for a redirect");
        if (redirect) begin
          wait_redirect = 1'b0;
          exp_pc        = npc;
          exp_known     = 1'b1;
        end
      end
      if (valid && next_ready) begin
        accepted++;
        if (waits_for_redirect(inst)) begin
          wait_redirect = 1'b1;
        end else begin
          exp_pc    = pc + 32'd4;
          exp_known = 1'b1;
          if (inst == FENCE_I_WORD) begin
            fences++;
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
              cached[2'(s)].valid = 1'b0;  // every line must be fetched again
            end
          end
        end
      end
      if (prev_arvalid && !prev_rvalid) begin
        assert (bus_arvalid) else log_fault("bus_arvalid_o dropped before bus_rvalid_i");
        assert (bus_araddr == prev_araddr)
          else report_mismatch("araddr_stable", prev_araddr, bus_araddr);
      end
      if (bus_arvalid && bus_rvalid) begin
        idx = bus_araddr[4:3];
        if (!beat_odd) begin
          assert (bus_araddr[2:0] == 3'b000)
            else report_mismatch("refill_even_addr", {bus_araddr[31:3], 3'b000}, bus_araddr);
          assert (!(cached[idx].valid && cached[idx].line == bus_araddr[31:3]))
            else log_fault("refill of a line that is still cached");
          refill_line = bus_araddr[31:3];
          beat_odd    = 1'b1;
        end else begin
          assert (bus_araddr == {refill_line, 3'b100})
            else report_mismatch("refill_odd_addr", {refill_line, 3'b100}, bus_araddr);
          cached[idx] = {1'b1, refill_line};  // evicts whatever the set held
          refills++;
          beat_odd = 1'b0;
        end
      end
    end
    rst_d        = rst;
    prev_valid   = valid && !rst;
    prev_ready   = next_ready;
    prev_pc      = pc;
    prev_inst    = inst;
    prev_arvalid = bus_arvalid && !rst;
    prev_rvalid  = bus_rvalid;
    prev_araddr  = bus_araddr;
  end

endmodule

`default_nettype wire

//--- fetch_top.f
source/rv_isa_pkg.sv
source/icache_pkg.sv
source/icache_array.sv
source/icache_refill.sv
source/fetch_ctrl.sv
source/fetch_top.sv
dv/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds fetch_tb with Verilator, runs it and decides the result from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module fetch_tb \
  -f fetch_top.f -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not succeed"
  exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0

//--- source/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  hit_i,
  input  rv_isa_pkg::inst_t     word_i,
  input  logic                  refill_busy_i,
  input  logic                  next_ready_i,
  input  logic                  redirect_i,
  input  icache_pkg::addr_t     npc_i,
  output icache_pkg::addr_t     pc_o,
  output rv_isa_pkg::inst_t     inst_o,
  output logic                  valid_o,
  output logic                  invalidate_o
);

  icache_pkg::addr_t pc_q;
  logic              stall_q;
  logic              accept;
  logic              stall_op;
  logic              fence_i_op;

  assign pc_o   = pc_q;
  assign inst_o = word_i;  // the array word holds as long as pc holds

  assign valid_o = hit_i && !stall_q && !refill_busy_i;
  assign accept  = valid_o && next_ready_i;

  assign stall_op   = rv_isa_pkg::is_stall_op(word_i);
  assign fence_i_op = rv_isa_pkg::is_fence_i(word_i);

  // the array clears on the same edge that moves pc past the fence.i
  assign invalidate_o = accept && fence_i_op;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= icache_pkg::PC_INIT;
      stall_q <= 1'b0;
    end else if (stall_q) begin
      if (redirect_i) begin
        pc_q    <= npc_i;  // core resolved the target
        stall_q <= 1'b0;
      end
    end else if (accept) begin
      if (stall_op) begin
        stall_q <= 1'b1;  // pc stays on the instruction until the redirect
      end else begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // the core only sends a target for something fetch is waiting on
  a_redirect_when_stalled: assert property (
    @(posedge clk) disable iff (rst)
    redirect_i |-> stall_q
  ) else $error("fetch_ctrl: redirect while not stalled");

endmodule

`default_nettype wire

//--- source/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  output icache_pkg::addr_t     bus_araddr_o,
  output logic                  bus_arvalid_o,
  input  rv_isa_pkg::inst_t     bus_rdata_i,
  input  logic                  bus_rvalid_i,
  input  logic                  next_ready_i,
  input  logic                  redirect_i,
  input  icache_pkg::addr_t     npc_i,
  output rv_isa_pkg::inst_t     inst_o,
  output icache_pkg::addr_t     pc_o,
  output logic                  valid_o
);

  logic              hit;
  rv_isa_pkg::inst_t word;
  icache_pkg::fill_t fill;
  logic              fill_we;
  logic              invalidate;
  logic              refill_busy;

  // refill is out of IDLE exactly when it requests on the bus or writes the array
  assign refill_busy = bus_arvalid_o || fill_we;

  icache_array u_array (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc_o),
    .fill_i       (fill),
    .fill_we_i    (fill_we),
    .invalidate_i (invalidate),
    .hit_o        (hit),
    .word_o       (word)
  );

  icache_refill u_refill (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (pc_o),
    .hit_i         (hit),
    .bus_araddr_o  (bus_araddr_o),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_rdata_i   (bus_rdata_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .fill_o        (fill),
    .fill_we_o     (fill_we)
  );

  fetch_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .hit_i         (hit),
    .word_i        (word),
    .refill_busy_i (refill_busy),
    .next_ready_i  (next_ready_i),
    .redirect_i    (redirect_i),
    .npc_i         (npc_i),
    .pc_o          (pc_o),
    .inst_o        (inst_o),
    .valid_o       (valid_o),
    .invalidate_o  (invalidate)
  );

endmodule

`default_nettype wire

//--- source/icache_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_array (
  input  logic                  clk,
  input  logic                  rst,
  input  icache_pkg::addr_t     pc_i,
  input  icache_pkg::fill_t     fill_i,
  input  logic                  fill_we_i,
  input  logic                  invalidate_i,
  output logic                  hit_o,
  output rv_isa_pkg::inst_t     word_o
);

  logic [icache_pkg::NUM_SETS-1:0] valid_q;
  icache_pkg::tag_t                tag_q  [icache_pkg::NUM_SETS];
  icache_pkg::line_t               data_q [icache_pkg::NUM_SETS];

  icache_pkg::index_t  pc_index;
  icache_pkg::tag_t    pc_tag;
  icache_pkg::offset_t pc_offset;
  icache_pkg::line_t   sel_line;

  assign pc_index  = icache_pkg::addr_index(pc_i);
  assign pc_tag    = icache_pkg::addr_tag(pc_i);
  assign pc_offset = icache_pkg::addr_offset(pc_i);

  assign sel_line = data_q[pc_index];

  // lookup is purely combinational so a hit shows in the same cycle as pc
  assign hit_o  = valid_q[pc_index] && (tag_q[pc_index] == pc_tag);
  assign word_o = pc_offset ? sel_line.word1 : sel_line.word0;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      valid_q <= '0;  // flash clear wins over a fill in the same cycle
    end else if (fill_we_i) begin
      valid_q[fill_i.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      tag_q[fill_i.index]  <= fill_i.tag;
      data_q[fill_i.index] <= fill_i.line;
    end
  end

  // a fence.i is only accepted from a hit, and the refill engine
  // is never writing while a hit is being handed out
  a_no_fill_during_inval: assert property (
    @(posedge clk) disable iff (rst)
    !(fill_we_i && invalidate_i)
  ) else $error("icache_array: fill and invalidate in the same cycle");

endmodule

`default_nettype wire

//--- source/icache_pkg.sv
`default_nettype none

package icache_pkg;

  typedef logic [31:0] addr_t;  // byte address, also used for pc

  localparam int unsigned NUM_SETS   = 4;
  localparam int unsigned LINE_WORDS = 2;

  // pc split, tag 31:5, index 4:3, offset 2, bits 1:0 always zero
  typedef logic [1:0]  index_t;
  typedef logic        offset_t;
  typedef logic [26:0] tag_t;

  typedef struct packed {
    rv_isa_pkg::inst_t word1;  // odd word, pc bit 2 set
    rv_isa_pkg::inst_t word0;  // even word
  } line_t;

  // one line write from the refill engine into the array
  typedef struct packed {
    index_t index;
    tag_t   tag;
    line_t  line;
  } fill_t;

  localparam addr_t PC_INIT = 32'h8000_0000;

  typedef enum logic [1:0] {
    IDLE,
    REQ_EVEN,
    REQ_ODD,
    WRITE
  } refill_state_t;

  function automatic index_t addr_index(input addr_t addr);
    return addr[4:3];
  endfunction

  function automatic tag_t addr_tag(input addr_t addr);
    return addr[31:5];
  endfunction

  function automatic offset_t addr_offset(input addr_t addr);
    return addr[2];
  endfunction

  // rebuilds a word address from its fields
  function automatic addr_t line_addr(input tag_t tag, input index_t index, input offset_t offset);
    return {tag, index, offset, 2'b00};
  endfunction

endpackage

`default_nettype wire

//--- source/icache_refill.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill (
  input  logic                  clk,
  input  logic                  rst,
  input  icache_pkg::addr_t     pc_i,
  input  logic                  hit_i,
  output icache_pkg::addr_t     bus_araddr_o,
  output logic                  bus_arvalid_o,
  input  rv_isa_pkg::inst_t     bus_rdata_i,
  input  logic                  bus_rvalid_i,
  output icache_pkg::fill_t     fill_o,
  output logic                  fill_we_o
);

  icache_pkg::refill_state_t state_q;
  icache_pkg::fill_t         fill_q;
  icache_pkg::offset_t       req_offset;

  // even beat first, the odd beat is the last word of the line
  assign req_offset = (state_q == icache_pkg::REQ_ODD) ?
                      icache_pkg::offset_t'(icache_pkg::LINE_WORDS - 1) : '0;

  assign bus_araddr_o  = icache_pkg::line_addr(fill_q.tag, fill_q.index, req_offset);
  assign bus_arvalid_o = (state_q == icache_pkg::REQ_EVEN) || (state_q == icache_pkg::REQ_ODD);

  assign fill_o    = fill_q;
  assign fill_we_o = (state_q == icache_pkg::WRITE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= icache_pkg::IDLE;
    end else begin
      unique case (state_q)
        icache_pkg::IDLE: begin
          if (!hit_i) begin
            state_q <= icache_pkg::REQ_EVEN;
          end
        end
        icache_pkg::REQ_EVEN: begin
          if (bus_rvalid_i) begin
            state_q <= icache_pkg::REQ_ODD;
          end
        end
        icache_pkg::REQ_ODD: begin
          if (bus_rvalid_i) begin
            state_q <= icache_pkg::WRITE;
          end
        end
        icache_pkg::WRITE: begin
          state_q <= icache_pkg::IDLE;  // array shows the hit one cycle later
        end
        default: begin
          state_q <= icache_pkg::IDLE;
        end
      endcase
    end
  end

  // line address and data, captured as the machine walks through its states
  always_ff @(posedge clk) begin
    if (state_q == icache_pkg::IDLE && !hit_i) begin
      fill_q.index <= icache_pkg::addr_index(pc_i);
      fill_q.tag   <= icache_pkg::addr_tag(pc_i);
    end
    if (state_q == icache_pkg::REQ_EVEN && bus_rvalid_i) begin
      fill_q.line.word0 <= bus_rdata_i;
    end
    if (state_q == icache_pkg::REQ_ODD && bus_rvalid_i) begin
      fill_q.line.word1 <= bus_rdata_i;
    end
  end

  a_arvalid_in_req: assert property (
    @(posedge clk) disable iff (rst)
    bus_arvalid_o |-> (state_q inside {icache_pkg::REQ_EVEN, icache_pkg::REQ_ODD})
  ) else $error("icache_refill: arvalid outside a request state");

  // the memory may take several cycles, the address must not move meanwhile
  a_araddr_stable: assert property (
    @(posedge clk) disable iff (rst)
    (bus_arvalid_o && !bus_rvalid_i) |=> $stable(bus_araddr_o)
  ) else $error("icache_refill: araddr changed while waiting for rvalid");

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] inst_t;  // one RV32 instruction word
  typedef logic [6:0]  opcode_t;  // major opcode, inst[6:0]

  // major opcodes that end sequential fetch
  localparam opcode_t OP_JAL    = 7'b110_1111;
  localparam opcode_t OP_JALR   = 7'b110_0111;
  localparam opcode_t OP_BRANCH = 7'b110_0011;
  localparam opcode_t OP_SYSTEM = 7'b111_0011;
  localparam opcode_t OP_LOAD   = 7'b000_0011;  // pc waits for the core after a load as well

  // fence.i is matched on the whole word, imm, rs1 and rd are all zero
  localparam inst_t INST_FENCE_I = 32'h0000_100f;

  function automatic opcode_t opcode_of(input inst_t inst);
    return inst[6:0];
  endfunction

  // true for the classes after which fetch waits for a redirect
  function automatic logic is_stall_op(input inst_t inst);
    opcode_t op;
    op = opcode_of(inst);
    return (op == OP_JAL) || (op == OP_JALR) || (op == OP_BRANCH) ||
           (op == OP_SYSTEM) || (op == OP_LOAD);
  endfunction

  function automatic logic is_fence_i(input inst_t inst);
    return inst == INST_FENCE_I;
  endfunction

endpackage

`default_nettype wire
